// File: blur_eq_top.sv
`timescale 1ns/1ps
/* top level: control, line buffer and the two gaussian kernels in lockstep. */
module blur_eq_top
    import blur_pkg::*;
#(
    parameter int IMG_WIDTH = 16
) (
    input  logic      clk,
    input  logic      rst_init,
    input  pix_in_t   in,
    input  logic      in_valid,
    input  logic      out_ready,
    output logic      in_ready,
    output blur_out_t out,
    output logic      out_valid,
    output row_cnt_t  mismatch_count
);

    logic  in_fire;
    logic  win_shift;
    logic  adv;
    col3_t col;
    pix_t  res_direct;
    pix_t  res_sep;

    eq_control #(
        .IMG_WIDTH (IMG_WIDTH)
    ) eq_control_inst (
        .clk            (clk),
        .rst_init       (rst_init),
        .in             (in),
        .in_valid       (in_valid),
        .out_ready      (out_ready),
        .res_direct     (res_direct),
        .res_sep        (res_sep),
        .in_ready       (in_ready),
        .in_fire        (in_fire),
        .win_shift      (win_shift),
        .adv            (adv),
        .out            (out),
        .out_valid      (out_valid),
        .mismatch_count (mismatch_count)
    );

    line_buffer #(
        .IMG_WIDTH (IMG_WIDTH)
    ) line_buffer_inst (
        .clk     (clk),
        .in_fire (in_fire),
        .pix     (in.pix),
        .col     (col)
    );

    gauss_direct gauss_direct_inst (
        .clk       (clk),
        .rst_init  (rst_init),
        .win_shift (win_shift),
        .adv       (adv),
        .col       (col),
        .res       (res_direct)
    );

    gauss_separable gauss_separable_inst (
        .clk       (clk),
        .rst_init  (rst_init),
        .win_shift (win_shift),
        .adv       (adv),
        .col       (col),
        .res       (res_sep)
    );

endmodule

// File: blur_pkg.sv
/* pixel, input stream, column and output stream types shared by the
   gaussian blur equivalence design. */
package blur_pkg;

    // one 8-bit grey level.
    typedef logic [7:0] pix_t;

    // input stream word; last marks the final pixel of a frame.
    typedef struct packed {
        pix_t pix;
        logic last;
    } pix_in_t;

    // one vertical column of the 3x3 window, bot is the newest row.
    typedef struct packed {
        pix_t top;
        pix_t mid;
        pix_t bot;
    } col3_t;

    // blurred output word; last is set on the final result of a frame.
    typedef struct packed {
        pix_t pix;
        logic last;
    } blur_out_t;

    // row position and mismatch counter width.
    typedef logic [15:0] row_cnt_t;

endpackage

// File: eq_control.sv
`timescale 1ns/1ps
/* row/column tracking, pipeline enable, stage flags, result comparison,
   mismatch counter and output register. */
module eq_control
    import blur_pkg::*;
#(
    parameter int IMG_WIDTH = 16
) (
    input  logic      clk,
    input  logic      rst_init,
    input  pix_in_t   in,
    input  logic      in_valid,
    input  logic      out_ready,
    input  pix_t      res_direct,
    input  pix_t      res_sep,
    output logic      in_ready,
    output logic      in_fire,
    output logic      win_shift,
    output logic      adv,
    output blur_out_t out,
    output logic      out_valid,
    output row_cnt_t  mismatch_count
);

    localparam int COL_W = $clog2(IMG_WIDTH);
    localparam logic [COL_W-1:0] LAST_COL = COL_W'(IMG_WIDTH - 1);

    // flags that travel with each pixel through the pipeline.
    typedef struct packed {
        logic valid;
        logic emit;
        logic last;
    } stage_t;

    logic [COL_W-1:0] col_cnt;
    row_cnt_t         row_cnt;
    stage_t           s1;
    stage_t           s2;
    logic             interior;
    logic             take;

    // the output register is the only place a stall can start.
    assign adv       = !out_valid || out_ready;
    assign in_ready  = adv;
    assign in_fire   = in_valid && adv;
    assign win_shift = adv && s1.valid;

    assign interior = (row_cnt >= row_cnt_t'(2)) && (col_cnt >= COL_W'(2));
    assign take     = s2.valid && s2.emit;

    always_ff @(posedge clk) begin
        if (rst_init) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (in_fire) begin
            if (in.last) begin
                col_cnt <= '0;
                row_cnt <= '0;
            end else if (col_cnt == LAST_COL) begin
                col_cnt <= '0;
                row_cnt <= row_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // stage 1 follows the line buffer, stage 2 the kernel results.
    always_ff @(posedge clk) begin
        if (rst_init) begin
            s1 <= '0;
            s2 <= '0;
        end else if (adv) begin
            s1.valid <= in_fire;
            s1.emit  <= in_fire && interior;
            s1.last  <= in_fire && in.last;
            s2       <= s1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            out_valid <= 1'b0;
        end else if (adv) begin
            out_valid <= take;
        end
    end

    // direct kernel result is the one handed on.
    always_ff @(posedge clk) begin
        if (adv && take) begin
            out.pix  <= res_direct;
            out.last <= s2.last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            mismatch_count <= '0;
        end else if (adv && take && (res_direct != res_sep)) begin
            if (mismatch_count != '1) begin
                mismatch_count <= mismatch_count + 1'b1;
            end
        end
    end

    // a stalled result stays put until the sink takes it.
    a_out_hold: assert property (@(posedge clk) disable iff (rst_init)
        out_valid && !out_ready |=> out_valid && $stable(out));

    // frames are whole rows.
    a_last_col: assert property (@(posedge clk) disable iff (rst_init)
        in_fire && in.last |-> col_cnt == LAST_COL);

endmodule

// File: gauss_direct.sv
`timescale 1ns/1ps
/* 3x3 window register and full 9-tap 1-2-1 by 1-2-1 gaussian kernel. */
module gauss_direct
    import blur_pkg::*;
(
    input  logic  clk,
    input  logic  rst_init,
    input  logic  win_shift,
    input  logic  adv,
    input  col3_t col,
    output pix_t  res
);

    // left and middle columns; the live col is the right one.
    col3_t win_l;
    col3_t win_m;

    logic [11:0] acc;
    logic [11:0] rounded;

    // corner taps weigh 1, edge taps 2, centre tap 4.
    always_comb begin
        acc = 12'(win_l.top)
            + (12'(win_l.mid) << 1)
            + 12'(win_l.bot)
            + (12'(win_m.top) << 1)
            + (12'(win_m.mid) << 2)
            + (12'(win_m.bot) << 1)
            + 12'(col.top)
            + (12'(col.mid) << 1)
            + 12'(col.bot);
    end

    // at most 16 * 255 + 8, so 12 bits hold it.
    assign rounded = acc + 12'd8;

    always_ff @(posedge clk) begin
        if (rst_init) begin
            win_l <= '0;
            win_m <= '0;
            res   <= '0;
        end else begin
            if (win_shift) begin
                win_l <= win_m;
                win_m <= col;
            end
            if (adv) begin
                res <= rounded[11:4];
            end
        end
    end

    // the window may only move while the whole pipeline advances.
    a_shift_adv: assert property (@(posedge clk) disable iff (rst_init)
        win_shift |-> adv);

endmodule

// File: gauss_separable.sv
`timescale 1ns/1ps
/* separable gaussian: vertical 1-2-1 column sums, then a horizontal
   1-2-1 filter over the sums. */
module gauss_separable
    import blur_pkg::*;
(
    input  logic  clk,
    input  logic  rst_init,
    input  logic  win_shift,
    input  logic  adv,
    input  col3_t col,
    output pix_t  res
);

    // vertical pass, at most 4 * 255.
    function automatic logic [9:0] col_sum(input col3_t c);
        return 10'(c.top) + (10'(c.mid) << 1) + 10'(c.bot);
    endfunction

    logic [9:0] sum_live;
    logic [9:0] sum_l;
    logic [9:0] sum_c;
    logic [11:0] horiz;
    logic [11:0] rounded;

    assign sum_live = col_sum(col);

    // horizontal pass over left, centre and the live column sum.
    assign horiz = 12'(sum_l) + (12'(sum_c) << 1) + 12'(sum_live);
    assign rounded = horiz + 12'd8;

    always_ff @(posedge clk) begin
        if (rst_init) begin
            sum_l <= '0;
            sum_c <= '0;
        end else if (win_shift) begin
            sum_l <= sum_c;
            sum_c <= sum_live;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            res <= '0;
        end else if (adv) begin
            res <= rounded[11:4];
        end
    end

endmodule

// File: line_buffer.sv
`timescale 1ns/1ps
/* two row memories that turn the pixel stream into vertical 3-pixel columns. */
module line_buffer
    import blur_pkg::*;
#(
    parameter int IMG_WIDTH = 16
) (
    input  logic  clk,
    input  logic  in_fire,
    input  pix_t  pix,
    output col3_t col
);

    localparam int COL_W = $clog2(IMG_WIDTH);
    localparam logic [COL_W-1:0] LAST_COL = COL_W'(IMG_WIDTH - 1);

    // row_prev holds the row above, row_old the one above that.
    pix_t row_prev [IMG_WIDTH];
    pix_t row_old  [IMG_WIDTH];

    // only the column phase matters, frames are whole rows.
    logic [COL_W-1:0] wr_col = '0;

    pix_t rd_prev;
    pix_t rd_old;

    assign rd_prev = row_prev[wr_col];
    assign rd_old  = row_old[wr_col];

    // read before write; the older row takes over the previous one in cascade.
    always_ff @(posedge clk) begin
        if (in_fire) begin
            row_old[wr_col]  <= rd_prev;
            row_prev[wr_col] <= pix;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            col.top <= rd_old;
            col.mid <= rd_prev;
            col.bot <= pix;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            if (wr_col == LAST_COL) begin
                wr_col <= '0;
            end else begin
                wr_col <= wr_col + 1'b1;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the blur equivalence testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_blur_eq

verilator --binary --assert --timescale 1ns/1ps -j 0 \
    --top-module "$TOP" -f sim.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
    echo "run passed"
    exit 0
fi

echo "run failed, see $LOG"
exit 1

// File: sim.f
blur_pkg.sv
line_buffer.sv
gauss_direct.sv
gauss_separable.sv
eq_control.sv
blur_eq_top.sv
tb_blur_eq.sv

// File: tb_blur_eq.sv
`timescale 1ns/1ps
/* testbench for blur_eq_top with clock, random frame stimulus, reference blur,
   output checks and watchdog. */
module tb_blur_eq
    import blur_pkg::*;
();

    localparam int IMG_WIDTH = 16;
    localparam int N_FRAMES = 5;
    localparam int MAX_ROWS = 6;
    localparam int TOTAL_ROWS = 5 + 4 + 3 + 6 + 3;
    localparam int TOTAL_PIXELS = TOTAL_ROWS * IMG_WIDTH;
    localparam logic [31:0] SEED = 32'hc33edc46;
    // rising edges from acceptance to out_valid.
    localparam int LATENCY = 3;

    logic      clk;
    logic      rst_init;
    pix_in_t   in_word;
    logic      in_valid;
    logic      out_ready;
    logic      in_ready;
    blur_out_t out_word;
    logic      out_valid;
    row_cnt_t  mismatch_count;

    pix_t        img [MAX_ROWS][IMG_WIDTH];
    blur_out_t   exp_q [$];
    logic [31:0] stim_rng;
    logic [31:0] sink_rng;
    bit          stall_en;
    int          value_errors;
    int          other_errors;

    blur_eq_top #(
        .IMG_WIDTH (IMG_WIDTH)
    ) blur_eq_top_inst (
        .clk            (clk),
        .rst_init       (rst_init),
        .in             (in_word),
        .in_valid       (in_valid),
        .out_ready      (out_ready),
        .in_ready       (in_ready),
        .out            (out_word),
        .out_valid      (out_valid),
        .mismatch_count (mismatch_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int frame_height(input int f);
        case (f)
            0: return 5;
            1: return 4;
            2: return 3;
            3: return 6;
            default: return 3;
        endcase
    endfunction

    // window ends at (r, c); weights are 1-2-1 in both directions.
    function automatic pix_t gauss_ref(input int r, input int c);
        int sum;
        int wr;
        int wc;
        sum = 0;
        for (int dr = 0; dr < 3; dr++) begin
            for (int dc = 0; dc < 3; dc++) begin
                wr = (dr == 1) ? 2 : 1;
                wc = (dc == 1) ? 2 : 1;
                sum += wr * wc * int'(img[r - 2 + dr][c - 2 + dc]);
            end
        end
        return pix_t'((sum + 8) >> 4);
    endfunction

    task automatic check_out(input blur_out_t got, input blur_out_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("MISMATCH at %0t: out pix %h last %b, expected pix %h last %b",
                     $time, got.pix, got.last, exp.pix, exp.last);
        end
    endtask

    task automatic check_count(input row_cnt_t got, input row_cnt_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // fills the frame store and queues every interior result.
    task automatic load_frame(input int h, input bit saturated);
        blur_out_t exp;
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < IMG_WIDTH; c++) begin
                stim_rng = xorshift32(stim_rng);
                img[r][c] = saturated ? 8'hff : stim_rng[7:0];
            end
        end
        for (int r = 2; r < h; r++) begin
            for (int c = 2; c < IMG_WIDTH; c++) begin
                exp.pix  = gauss_ref(r, c);
                exp.last = (r == h - 1) && (c == IMG_WIDTH - 1);
                exp_q.push_back(exp);
            end
        end
    endtask

    task automatic send_frame(input int h, input bit gaps);
        int n_gap;
        bit accepted;
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < IMG_WIDTH; c++) begin
                n_gap = 0;
                if (gaps) begin
                    stim_rng = xorshift32(stim_rng);
                    if (stim_rng[1:0] == 2'b00) begin
                        n_gap = int'(stim_rng[3:2]) + 1;
                    end
                end
                in_valid = 1'b0;
                repeat (n_gap) @(negedge clk);
                in_word.pix  = img[r][c];
                in_word.last = (r == h - 1) && (c == IMG_WIDTH - 1);
                in_valid     = 1'b1;
                accepted     = 1'b0;
                while (!accepted) begin
                    @(posedge clk);
                    accepted = in_ready;
                    @(negedge clk);
                end
            end
        end
        in_valid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // sink side with random stalls once enabled.
    initial begin
        sink_rng  = SEED ^ 32'h9e3779b9;
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (stall_en) begin
                sink_rng  = xorshift32(sink_rng);
                out_ready = (sink_rng[1:0] != 2'b00);
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    initial begin : monitor
        blur_out_t exp;
        blur_out_t held;
        bit        holding;
        holding = 1'b0;
        forever begin
            @(posedge clk);
            if (holding && (out_valid !== 1'b1 || out_word !== held)) begin
                other_errors++;
                $display("ERROR at %0t: output changed or dropped during a stall", $time);
            end
            holding = 1'b0;
            if (!rst_init && out_valid === 1'b1) begin
                if (out_ready) begin
                    if (exp_q.size() == 0) begin
                        other_errors++;
                        $display("ERROR at %0t: result with no expected value left", $time);
                    end else begin
                        exp = exp_q.pop_front();
                        check_out(out_word, exp);
                    end
                end else begin
                    held    = out_word;
                    holding = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = 20 * TOTAL_PIXELS + 200;
        repeat (limit) @(posedge clk);
        $display("ERROR: timeout after %0d cycles with %0d results outstanding",
                 limit, exp_q.size());
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : stimulus
        int h;
        stim_rng     = SEED;
        stall_en     = 1'b0;
        value_errors = 0;
        other_errors = 0;
        rst_init     = 1'b1;
        in_word      = '0;
        in_valid     = 1'b0;
        repeat (4) @(negedge clk);
        rst_init = 1'b0;

        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            other_errors++;
            $display("ERROR: out_valid low and in_ready high not seen after reset");
        end
        check_count(mismatch_count, row_cnt_t'(0), "mismatch_count after reset");

        // frame 0 runs at full rate and the rest follow back to back with gaps and stalls.
        for (int f = 0; f < N_FRAMES; f++) begin
            h = frame_height(f);
            load_frame(h, f == 2);
            if (f == 1) begin
                stall_en = 1'b1;
            end
            send_frame(h, f != 0);
        end

        stall_en = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (LATENCY) @(negedge clk);
        check_count(mismatch_count, row_cnt_t'(0), "mismatch_count at end");

        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
